/* hdl/mul_pkg.sv */
`default_nettype none

package mul_pkg;

    // Signed two's-complement multiplier operand
    typedef logic signed [15:0] operand_t;

    // Full-width signed product, wraps modulo 2^32
    typedef logic signed [31:0] product_t;

    typedef logic [31:0] err_t;     // Absolute error magnitude
    typedef logic [15:0] count_t;   // Saturating statistics counter

    // Cycles from an input strobe to the product valid pulse
    localparam int unsigned MUL_LATENCY = 2;

    // The approximated rows only reach bit 22 of the sum
    localparam err_t ERR_BOUND = 32'h0100_0000;

endpackage

`default_nettype wire

/* hdl/prod_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Registered products from the multiplier stage to the error monitor
interface prod_if (
    input logic clk
);

    logic               valid;      // One-cycle pulse per sample
    mul_pkg::product_t  approx;     // Only meaningful while valid is high
    mul_pkg::product_t  exact;

    modport source (
        input  clk,
        output valid,
        output approx,
        output exact
    );

    modport sink (
        input  clk,
        input  valid,
        input  approx,
        input  exact
    );

endinterface

`default_nettype wire

/* hdl/approx_mul_16.sv */
`timescale 1ns/1ps
`default_nettype none

module approx_mul_16 (
    input  mul_pkg::operand_t x,
    input  mul_pkg::operand_t y,
    output mul_pkg::product_t z
);

    // Baugh-Wooley partial products, one row per bit of x
    logic [15:0] pp [16];

    // Sparse correction terms standing in for rows 0 to 5
    logic [20:0] corr [6];

    for (genvar i = 0; i < 15; i++) begin : g_row
        assign pp[i] = {~(y[15] & x[i]), y[14:0] & {15{x[i]}}};
    end

    // The last row has its sign column inverted the other way
    assign pp[15] = {y[15] & x[15], ~(y[14:0] & {15{x[15]}})};

    always_comb begin
        for (int k = 0; k < 6; k++) begin
            corr[k] = '0;
        end

        corr[0][3]  = pp[0][3] | pp[1][2];
        corr[0][5]  = pp[0][4] & pp[1][3];
        corr[0][10] = pp[4][5] & pp[5][4];
        corr[0][11] = pp[0][11] ^ pp[1][10];
        corr[0][13] = pp[0][12] & pp[1][11];
        corr[0][15] = pp[4][10] & pp[5][9];
        // Row 1 sign bit plus the constant one at bit 16, as sum and carry
        corr[0][16] = ~pp[1][15];
        corr[0][17] = pp[1][15];
        corr[0][18] = pp[3][15];
        corr[0][19] = pp[4][14] & pp[5][13];
        corr[0][20] = pp[4][15] & pp[5][14];

        corr[1][3]  = pp[0][3] ^ pp[1][2];
        corr[1][5]  = pp[0][4] ^ pp[1][3];
        corr[1][13] = pp[2][11] ^ pp[3][10];
        corr[1][16] = pp[4][12] ^ pp[5][11];
        corr[1][17] = pp[2][14] ^ pp[3][13];
        corr[1][18] = pp[4][13] | pp[5][12];
        corr[1][19] = pp[4][15] ^ pp[5][14];
        corr[1][20] = pp[5][15];

        corr[2][5]  = pp[2][3] ^ pp[3][2];
        corr[2][17] = pp[2][15] ^ pp[3][14];

        corr[3][17] = pp[4][12] & pp[5][11];

        corr[4][17] = pp[4][12] ^ pp[5][11];

        corr[5][17] = pp[4][13] ^ pp[5][12];
    end

    always_comb begin
        z = 32'sh8000_0000;     // Constant one at bit 31
        for (int i = 6; i < 16; i++) begin
            z = z + (mul_pkg::product_t'(pp[i]) << i);  // Exact rows at their weight
        end
        for (int k = 0; k < 6; k++) begin
            z = z + mul_pkg::product_t'(corr[k]);
        end
    end

endmodule

`default_nettype wire

/* hdl/mul_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  mul_pkg::operand_t x,
    input  mul_pkg::operand_t y,
    prod_if.source            out
);

    mul_pkg::operand_t x_q;
    mul_pkg::operand_t y_q;
    logic              valid_q;
    mul_pkg::product_t approx_d;

    approx_mul_16 i_approx_mul_16 (
        .x (x_q),
        .y (y_q),
        .z (approx_d)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q   <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            valid_q   <= in_valid;
            out.valid <= valid_q;
        end
    end

    // Operands only load on a strobe so idle cycles leave the datapath still
    always_ff @(posedge clk) begin
        if (in_valid) begin
            x_q <= x;
            y_q <= y;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_q) begin
            out.approx <= approx_d;
            out.exact  <= mul_pkg::product_t'(x_q) * mul_pkg::product_t'(y_q);
        end
    end

    // A product pulse always traces back to a strobe MUL_LATENCY cycles earlier
    a_valid_from_strobe: assert property (
        @(posedge out.clk) disable iff (rst)
        out.valid |-> $past(in_valid, mul_pkg::MUL_LATENCY)
    );

endmodule

`default_nettype wire

/* hdl/error_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module error_monitor (
    input  logic            clk,
    input  logic            rst,
    input  logic            clear,
    prod_if.sink            in,
    output mul_pkg::err_t   max_err,
    output mul_pkg::count_t sample_count,
    output mul_pkg::count_t hit_count
);

    mul_pkg::product_t diff;
    mul_pkg::err_t     abs_err;
    logic              hit;

    // Wrapped difference, so a full-scale miss still gives a true magnitude
    assign diff    = in.approx - in.exact;
    assign abs_err = diff[31] ? mul_pkg::err_t'(-diff) : mul_pkg::err_t'(diff);
    assign hit     = (abs_err == '0);

    always_ff @(posedge clk) begin
        if (rst || clear) begin     // Clear wins over a sample landing in the same cycle
            max_err      <= '0;
            sample_count <= '0;
            hit_count    <= '0;
        end else if (in.valid) begin
            if (abs_err > max_err) begin
                max_err <= abs_err;
            end

            if (sample_count != '1) begin
                sample_count <= sample_count + 1'b1;
            end

            if (hit && (hit_count != '1)) begin
                hit_count <= hit_count + 1'b1;
            end
        end
    end

    // The truncated rows of the multiplier must stay below the error bound
    a_err_bounded: assert property (
        @(posedge in.clk) disable iff (rst)
        in.valid |-> (abs_err < mul_pkg::ERR_BOUND)
    );

endmodule

`default_nettype wire

/* hdl/approx_mul_top.sv */
`timescale 1ns/1ps
`default_nettype none

module approx_mul_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  mul_pkg::operand_t x,
    input  mul_pkg::operand_t y,
    input  logic              clear,
    output logic              out_valid,
    output mul_pkg::product_t product,
    output mul_pkg::product_t exact_product,
    output mul_pkg::err_t     max_err,
    output mul_pkg::count_t   sample_count,
    output mul_pkg::count_t   hit_count
);

    prod_if i_prod_if (
        .clk (clk)
    );

    mul_stage i_mul_stage (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .x        (x),
        .y        (y),
        .out      (i_prod_if.source)
    );

    error_monitor i_error_monitor (
        .clk          (clk),
        .rst          (rst),
        .clear        (clear),
        .in           (i_prod_if.sink),
        .max_err      (max_err),
        .sample_count (sample_count),
        .hit_count    (hit_count)
    );

    // Products leave at the same time the monitor sees them
    assign out_valid     = i_prod_if.valid;
    assign product       = i_prod_if.approx;
    assign exact_product = i_prod_if.exact;

endmodule

`default_nettype wire

/* bench/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);

    localparam time HALF_NS    = 20;    // 40 ns period
    localparam int  RST_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_NS clk = ~clk;
    end

    // Reset spans the first 16 rising edges
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* bench/tb_approx_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_approx_mul;

    localparam int        TAB_LEN     = 14;
    localparam int        RAND_COUNT  = 48;
    localparam int        GAP_EVERY   = 5;     // One idle cycle after every fifth sample
    localparam time       PERIOD_NS   = 40;
    localparam time       WATCHDOG_NS = (TAB_LEN + RAND_COUNT + 50) * PERIOD_NS;
    localparam bit [31:0] SEED        = 32'h6fad_fa0d;

    typedef struct packed {
        mul_pkg::operand_t x;
        mul_pkg::operand_t y;
        mul_pkg::product_t exact;
    } vec_t;

    // Corner operands with hand-worked exact products
    vec_t vec_tab [TAB_LEN] = '{
        '{16'sh0000, 16'sh0000, 32'sh0000_0000},
        '{16'sh0000, 16'sh7fff, 32'sh0000_0000},
        '{16'sh0001, 16'sh0001, 32'sh0000_0001},
        '{16'shffff, 16'sh0001, 32'shffff_ffff},
        '{16'shffff, 16'shffff, 32'sh0000_0001},
        '{16'sh0001, 16'sh8000, 32'shffff_8000},
        '{16'sh8000, 16'sh8000, 32'sh4000_0000},
        '{16'sh8000, 16'sh7fff, 32'shc000_8000},
        '{16'sh7fff, 16'sh7fff, 32'sh3fff_0001},
        '{16'sh7fff, 16'shffff, 32'shffff_8001},
        '{16'sh0064, 16'shff38, 32'shffff_b1e0},   // 100 * -200
        '{16'shfb2e, 16'sh162e, 32'shff95_1644},   // -1234 * 5678
        '{16'shfed4, 16'shfe70, 32'sh0001_d4c0},   // -300 * -400
        '{16'sh3039, 16'shffff, 32'shffff_cfc7}
    };

    logic              clk;
    logic              rst;
    logic              in_valid;
    mul_pkg::operand_t x;
    mul_pkg::operand_t y;
    logic              clear;
    logic              out_valid;
    mul_pkg::product_t product;
    mul_pkg::product_t exact_product;
    mul_pkg::err_t     max_err;
    mul_pkg::count_t   sample_count;
    mul_pkg::count_t   hit_count;

    // Reference model of the statistics and the samples in flight
    mul_pkg::product_t exp_q [$];
    time               due_q [$];
    mul_pkg::count_t   exp_samples;
    mul_pkg::count_t   exp_hits;
    mul_pkg::err_t     exp_max;
    bit                stats_due;

    clk_gen i_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    approx_mul_top i_approx_mul_top (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .x             (x),
        .y             (y),
        .clear         (clear),
        .out_valid     (out_valid),
        .product       (product),
        .exact_product (exact_product),
        .max_err       (max_err),
        .sample_count  (sample_count),
        .hit_count     (hit_count)
    );

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_product(input string name, input mul_pkg::product_t got,
                                 input mul_pkg::product_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_err(input string name, input mul_pkg::err_t got,
                             input mul_pkg::err_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input mul_pkg::count_t got,
                               input mul_pkg::count_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_stats();
        check_err("max_err", max_err, exp_max);
        check_count("sample_count", sample_count, exp_samples);
        check_count("hit_count", hit_count, exp_hits);
    endtask

    function automatic mul_pkg::product_t signed_product(input mul_pkg::operand_t a,
                                                         input mul_pkg::operand_t b);
        return mul_pkg::product_t'(longint'(a) * longint'(b));
    endfunction

    // Magnitude of the difference taken modulo 2^32
    function automatic mul_pkg::err_t abs_diff(input mul_pkg::product_t a,
                                               input mul_pkg::product_t b);
        longint d;
        d = longint'(mul_pkg::product_t'(a - b));
        return mul_pkg::err_t'((d < 0) ? -d : d);
    endfunction

    task automatic take_pulse();
        mul_pkg::product_t exp;
        mul_pkg::err_t     err;
        exp = exp_q.pop_front();
        due_q.delete(0);
        if (out_valid !== 1'b1) begin
            $display("No out_valid pulse at %0t ns although a sample was due", $time);
            abort_run();
        end
        check_product("exact_product", exact_product, exp);
        err = abs_diff(product, exp);
        if ((^product === 1'bx) || (err >= mul_pkg::ERR_BOUND)) begin
            $display("Approximate product %h is too far from exact %h at %0t ns",
                     product, exp, $time);
            abort_run();
        end
        if (exp_samples != '1) begin
            exp_samples = exp_samples + 16'd1;
        end
        if ((product == exp) && (exp_hits != '1)) begin
            exp_hits = exp_hits + 16'd1;
        end
        if (err > exp_max) begin
            exp_max = err;
        end
        stats_due = 1'b1;   // The monitor shows this sample one edge later
    endtask

    task automatic apply_sample(input mul_pkg::operand_t a, input mul_pkg::operand_t b,
                                input mul_pkg::product_t exact);
        @(negedge clk);
        in_valid = 1'b1;
        x        = a;
        y        = b;
        exp_q.push_back(exact);
        due_q.push_back($time + mul_pkg::MUL_LATENCY * PERIOD_NS);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Waits until every sample has come out and its statistics were checked
    task automatic drain();
        idle_cycle();
        while ((exp_q.size() != 0) || stats_due) begin
            @(negedge clk);
        end
    endtask

    task automatic clear_stats();
        drain();
        clear = 1'b1;
        @(negedge clk);
        clear       = 1'b0;
        exp_samples = '0;
        exp_hits    = '0;
        exp_max     = '0;
        check_stats();
    endtask

    // Output monitor, sampling on falling edges where the registered outputs are stable
    initial begin
        @(negedge rst);
        forever begin
            @(negedge clk);
            if (stats_due) begin
                check_stats();
                stats_due = 1'b0;
            end
            if ((due_q.size() != 0) && (due_q[0] == $time)) begin
                take_pulse();
            end else if (out_valid !== 1'b0) begin
                $display("Unexpected out_valid at %0t ns with no sample due", $time);
                abort_run();
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0t ns, the run did not finish", $time);
        abort_run();
    end

    initial begin
        mul_pkg::operand_t a;
        mul_pkg::operand_t b;
        int                n;
        in_valid    = 1'b0;
        clear       = 1'b0;
        x           = '0;
        y           = '0;
        exp_samples = '0;
        exp_hits    = '0;
        exp_max     = '0;
        stats_due   = 1'b0;
        n           = 0;
        void'($urandom(SEED));

        @(negedge rst);
        @(negedge clk);
        check_stats();      // Statistics come out of reset at zero

        for (int i = 0; i < TAB_LEN; i++) begin
            apply_sample(vec_tab[i].x, vec_tab[i].y, vec_tab[i].exact);
            n++;
            if ((n % GAP_EVERY) == 0) begin
                idle_cycle();
            end
        end

        clear_stats();

        for (int i = 0; i < RAND_COUNT; i++) begin
            a = mul_pkg::operand_t'($urandom());
            b = mul_pkg::operand_t'($urandom());
            apply_sample(a, b, signed_product(a, b));
            n++;
            if ((n % GAP_EVERY) == 0) begin
                idle_cycle();
            end
        end

        drain();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hdl/mul_pkg.sv
hdl/prod_if.sv
hdl/approx_mul_16.sv
hdl/mul_stage.sv
hdl/error_monitor.sv
hdl/approx_mul_top.sv
bench/clk_gen.sv
bench/tb_approx_mul.sv

/* run_sim.sh */
#!/bin/sh
# Compiles the testbench with Verilator, runs it and decides on the log contents
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_approx_mul -o sim_tb > sim.log 2>&1 \
    && ./obj_dir/sim_tb >> sim.log 2>&1

grep -q "^TEST PASSED$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
